// File: include/id_cfg.svh
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// data path width
`define ID_XLEN 32

// register file index, 32 entries
`define ID_REG_ADDR_W 5

// fixed 32-bit encodings only, no compressed forms
`define ID_INST_W 32

// return address is the next sequential instruction
`define ID_LINK_OFFSET 4

`endif

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_I_ALU = 7'b0010011;
	localparam logic [6:0] OPC_R_ALU = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;

	// integer alu funct3, shared by the I and R forms
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// M extension funct3
	localparam logic [2:0] F3_MUL = 3'b000;
	localparam logic [2:0] F3_MULH = 3'b001;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU = 3'b011;
	localparam logic [2:0] F3_DIV = 3'b100;
	localparam logic [2:0] F3_DIVU = 3'b101;
	localparam logic [2:0] F3_REM = 3'b110;
	localparam logic [2:0] F3_REMU = 3'b111;

	// branch funct3
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load and store widths
	localparam logic [2:0] F3_LB = 3'b000;
	localparam logic [2:0] F3_LH = 3'b001;
	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB, SRA, SRAI
	localparam logic [6:0] F7_MEXT = 7'b0000001;

endpackage

`default_nettype wire

// File: rtl/id_ctrl_pkg.sv
`default_nettype none

`include "id_cfg.svh"

package id_ctrl_pkg;

	typedef logic [`ID_XLEN-1:0] word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`ID_INST_W-1:0] inst_t;

	// NOP must stay zero, a bubble is built from it
	typedef enum logic [5:0] {
		ALU_NOP, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
		ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
		ALU_JAL, ALU_JALR,
		ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW,
		ALU_SB, ALU_SH, ALU_SW
	} alu_op_e;

	// result class, picks the EX functional unit
	typedef enum logic [2:0] {
		SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH,
		SEL_MUL, SEL_DIV, SEL_JUMP_BRANCH, SEL_LOAD_STORE
	} alu_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		alu_sel_e alu_sel;
		logic rs1_read;
		logic rs2_read;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic rd_write;
		logic op1_is_pc;  // AUIPC
		logic is_branch;
		logic is_jal;
		logic is_jalr;
	} id_ctrl_t;

	// pending register write of a later stage
	typedef struct packed {
		logic we;
		reg_addr_t rd;
		word_t data;
	} fwd_t;

	typedef struct packed {
		alu_op_e alu_op;
		alu_sel_e alu_sel;
		word_t op1;
		word_t op2;
		reg_addr_t rd;
		logic rd_write;
		word_t link;
	} id_ex_t;

	typedef struct packed {
		logic taken;
		word_t target;
		word_t link;
	} branch_t;

endpackage

`default_nettype wire

// File: rtl/id_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module id_decoder (
	input id_ctrl_pkg::inst_t inst_i,
	output id_ctrl_pkg::id_ctrl_t ctrl_o,
	output id_ctrl_pkg::word_t imm_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	id_ctrl_pkg::word_t imm_i_type;
	id_ctrl_pkg::word_t imm_u_type;
	id_ctrl_pkg::word_t imm_b_type;
	id_ctrl_pkg::word_t imm_j_type;
	id_ctrl_pkg::word_t imm_shamt;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_shamt = {27'b0, inst_i[24:20]};

	always_comb begin
		ctrl_o.alu_op = id_ctrl_pkg::ALU_NOP;
		ctrl_o.alu_sel = id_ctrl_pkg::SEL_NOP;
		ctrl_o.rs1_read = 1'b0;
		ctrl_o.rs2_read = 1'b0;
		ctrl_o.rs1 = inst_i[19:15];
		ctrl_o.rs2 = inst_i[24:20];
		ctrl_o.rd = inst_i[11:7];
		ctrl_o.rd_write = 1'b0;
		ctrl_o.op1_is_pc = 1'b0;
		ctrl_o.is_branch = 1'b0;
		ctrl_o.is_jal = 1'b0;
		ctrl_o.is_jalr = 1'b0;
		imm_o = '0;

		case (opcode)
			rv_isa_pkg::OPC_I_ALU: begin
				case (funct3)
					rv_isa_pkg::F3_ADD_SUB: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SEL_ARITH};
					rv_isa_pkg::F3_SLT: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLT, id_ctrl_pkg::SEL_ARITH};
					rv_isa_pkg::F3_SLTU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLTU, id_ctrl_pkg::SEL_ARITH};
					rv_isa_pkg::F3_XOR: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_XOR, id_ctrl_pkg::SEL_LOGIC};
					rv_isa_pkg::F3_OR: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_OR, id_ctrl_pkg::SEL_LOGIC};
					rv_isa_pkg::F3_AND: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_AND, id_ctrl_pkg::SEL_LOGIC};
					rv_isa_pkg::F3_SLL: begin
						if (funct7 == rv_isa_pkg::F7_BASE) begin
							{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLL, id_ctrl_pkg::SEL_SHIFT};
						end
					end
					rv_isa_pkg::F3_SRL_SRA: begin
						if (funct7 == rv_isa_pkg::F7_BASE) begin
							{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SRL, id_ctrl_pkg::SEL_SHIFT};
						end else if (funct7 == rv_isa_pkg::F7_ALT) begin
							{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SRA, id_ctrl_pkg::SEL_SHIFT};
						end
					end
					default: ;
				endcase
				if (ctrl_o.alu_op != id_ctrl_pkg::ALU_NOP) begin
					ctrl_o.rs1_read = 1'b1;
					ctrl_o.rd_write = 1'b1;
					// shifts carry only shamt
					imm_o = (ctrl_o.alu_sel == id_ctrl_pkg::SEL_SHIFT) ? imm_shamt : imm_i_type;
				end
			end
			rv_isa_pkg::OPC_R_ALU: begin
				if (funct7 == rv_isa_pkg::F7_MEXT) begin
					ctrl_o.alu_sel = funct3[2] ? id_ctrl_pkg::SEL_DIV : id_ctrl_pkg::SEL_MUL;
					case (funct3)
						rv_isa_pkg::F3_MUL: ctrl_o.alu_op = id_ctrl_pkg::ALU_MUL;
						rv_isa_pkg::F3_MULH: ctrl_o.alu_op = id_ctrl_pkg::ALU_MULH;
						rv_isa_pkg::F3_MULHSU: ctrl_o.alu_op = id_ctrl_pkg::ALU_MULHSU;
						rv_isa_pkg::F3_MULHU: ctrl_o.alu_op = id_ctrl_pkg::ALU_MULHU;
						rv_isa_pkg::F3_DIV: ctrl_o.alu_op = id_ctrl_pkg::ALU_DIV;
						rv_isa_pkg::F3_DIVU: ctrl_o.alu_op = id_ctrl_pkg::ALU_DIVU;
						rv_isa_pkg::F3_REM: ctrl_o.alu_op = id_ctrl_pkg::ALU_REM;
						default: ctrl_o.alu_op = id_ctrl_pkg::ALU_REMU;
					endcase
				end else if (funct7 == rv_isa_pkg::F7_BASE) begin
					case (funct3)
						rv_isa_pkg::F3_ADD_SUB: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SEL_ARITH};
						rv_isa_pkg::F3_SLL: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLL, id_ctrl_pkg::SEL_SHIFT};
						rv_isa_pkg::F3_SLT: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLT, id_ctrl_pkg::SEL_ARITH};
						rv_isa_pkg::F3_SLTU: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SLTU, id_ctrl_pkg::SEL_ARITH};
						rv_isa_pkg::F3_XOR: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_XOR, id_ctrl_pkg::SEL_LOGIC};
						rv_isa_pkg::F3_SRL_SRA: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SRL, id_ctrl_pkg::SEL_SHIFT};
						rv_isa_pkg::F3_OR: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_OR, id_ctrl_pkg::SEL_LOGIC};
						default: {ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_AND, id_ctrl_pkg::SEL_LOGIC};
					endcase
				end else if (funct7 == rv_isa_pkg::F7_ALT) begin
					if (funct3 == rv_isa_pkg::F3_ADD_SUB) begin
						{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SUB, id_ctrl_pkg::SEL_ARITH};
					end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
						{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_SRA, id_ctrl_pkg::SEL_SHIFT};
					end
				end
				if (ctrl_o.alu_op != id_ctrl_pkg::ALU_NOP) begin
					ctrl_o.rs1_read = 1'b1;
					ctrl_o.rs2_read = 1'b1;
					ctrl_o.rd_write = 1'b1;
				end
			end
			rv_isa_pkg::OPC_BRANCH: begin
				case (funct3)
					rv_isa_pkg::F3_BEQ: ctrl_o.alu_op = id_ctrl_pkg::ALU_BEQ;
					rv_isa_pkg::F3_BNE: ctrl_o.alu_op = id_ctrl_pkg::ALU_BNE;
					rv_isa_pkg::F3_BLT: ctrl_o.alu_op = id_ctrl_pkg::ALU_BLT;
					rv_isa_pkg::F3_BGE: ctrl_o.alu_op = id_ctrl_pkg::ALU_BGE;
					rv_isa_pkg::F3_BLTU: ctrl_o.alu_op = id_ctrl_pkg::ALU_BLTU;
					rv_isa_pkg::F3_BGEU: ctrl_o.alu_op = id_ctrl_pkg::ALU_BGEU;
					default: ;  // 010, 011 reserved
				endcase
				if (ctrl_o.alu_op != id_ctrl_pkg::ALU_NOP) begin
					ctrl_o.alu_sel = id_ctrl_pkg::SEL_JUMP_BRANCH;
					ctrl_o.rs1_read = 1'b1;
					ctrl_o.rs2_read = 1'b1;
					ctrl_o.is_branch = 1'b1;
					imm_o = imm_b_type;
				end
			end
			rv_isa_pkg::OPC_LOAD: begin
				case (funct3)
					rv_isa_pkg::F3_LB: ctrl_o.alu_op = id_ctrl_pkg::ALU_LB;
					rv_isa_pkg::F3_LH: ctrl_o.alu_op = id_ctrl_pkg::ALU_LH;
					rv_isa_pkg::F3_LW: ctrl_o.alu_op = id_ctrl_pkg::ALU_LW;
					rv_isa_pkg::F3_LBU: ctrl_o.alu_op = id_ctrl_pkg::ALU_LBU;
					rv_isa_pkg::F3_LHU: ctrl_o.alu_op = id_ctrl_pkg::ALU_LHU;
					default: ;
				endcase
				if (ctrl_o.alu_op != id_ctrl_pkg::ALU_NOP) begin
					ctrl_o.alu_sel = id_ctrl_pkg::SEL_LOAD_STORE;
					ctrl_o.rs1_read = 1'b1;
					ctrl_o.rd_write = 1'b1;
					imm_o = imm_i_type;  // address offset
				end
			end
			rv_isa_pkg::OPC_STORE: begin
				case (funct3)
					rv_isa_pkg::F3_SB: ctrl_o.alu_op = id_ctrl_pkg::ALU_SB;
					rv_isa_pkg::F3_SH: ctrl_o.alu_op = id_ctrl_pkg::ALU_SH;
					rv_isa_pkg::F3_SW: ctrl_o.alu_op = id_ctrl_pkg::ALU_SW;
					default: ;
				endcase
				if (ctrl_o.alu_op != id_ctrl_pkg::ALU_NOP) begin
					ctrl_o.alu_sel = id_ctrl_pkg::SEL_LOAD_STORE;
					ctrl_o.rs1_read = 1'b1;
					ctrl_o.rs2_read = 1'b1;
				end
			end
			rv_isa_pkg::OPC_LUI: begin  // x0 | imm
				{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_OR, id_ctrl_pkg::SEL_LOGIC};
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.rs1 = '0;
				ctrl_o.rd_write = 1'b1;
				imm_o = imm_u_type;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SEL_ARITH};
				ctrl_o.op1_is_pc = 1'b1;
				ctrl_o.rd_write = 1'b1;
				imm_o = imm_u_type;
			end
			rv_isa_pkg::OPC_JAL: begin
				{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_JAL, id_ctrl_pkg::SEL_JUMP_BRANCH};
				ctrl_o.rd = id_ctrl_pkg::reg_addr_t'(1);  // link always to x1
				ctrl_o.rd_write = 1'b1;
				ctrl_o.is_jal = 1'b1;
				imm_o = imm_j_type;
			end
			rv_isa_pkg::OPC_JALR: begin
				{ctrl_o.alu_op, ctrl_o.alu_sel} = {id_ctrl_pkg::ALU_JALR, id_ctrl_pkg::SEL_JUMP_BRANCH};
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.rd = id_ctrl_pkg::reg_addr_t'(1);
				ctrl_o.rd_write = 1'b1;
				ctrl_o.is_jalr = 1'b1;
				imm_o = imm_i_type;
			end
			default: ;  // unknown opcode stays NOP
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/id_operand_mux.sv
`timescale 1ns/10ps
`default_nettype none

module id_operand_mux (
	input id_ctrl_pkg::id_ctrl_t ctrl_i,
	input id_ctrl_pkg::word_t imm_i,
	input id_ctrl_pkg::word_t pc_i,
	input id_ctrl_pkg::word_t rs1_data_i,
	input id_ctrl_pkg::word_t rs2_data_i,
	input id_ctrl_pkg::fwd_t ex_fwd_i,
	input id_ctrl_pkg::fwd_t mem_fwd_i,
	input id_ctrl_pkg::alu_op_e ex_alu_op_i,
	input id_ctrl_pkg::reg_addr_t ex_rd_i,
	output id_ctrl_pkg::word_t op1_o,
	output id_ctrl_pkg::word_t op2_o,
	output logic stall_o
);

	logic ex_is_load;
	logic rs1_hazard;
	logic rs2_hazard;

	// EX over MEM over register file, x0 is never forwarded
	function automatic id_ctrl_pkg::word_t pick_operand(
		input logic read_en,
		input id_ctrl_pkg::reg_addr_t addr,
		input id_ctrl_pkg::word_t rf_data,
		input id_ctrl_pkg::word_t alt,
		input id_ctrl_pkg::fwd_t ex,
		input id_ctrl_pkg::fwd_t mem
	);
		id_ctrl_pkg::word_t result;
		result = rf_data;
		if (!read_en) begin
			result = alt;
		end else if (addr != '0 && ex.we && ex.rd == addr) begin
			result = ex.data;
		end else if (addr != '0 && mem.we && mem.rd == addr) begin
			result = mem.data;
		end
		return result;
	endfunction

	assign op1_o = pick_operand(ctrl_i.rs1_read, ctrl_i.rs1, rs1_data_i,
		ctrl_i.op1_is_pc ? pc_i : imm_i, ex_fwd_i, mem_fwd_i);
	assign op2_o = pick_operand(ctrl_i.rs2_read, ctrl_i.rs2, rs2_data_i, imm_i,
		ex_fwd_i, mem_fwd_i);

	// load data only exists after MEM, so a dependent reader has to wait
	assign ex_is_load = ex_alu_op_i inside {id_ctrl_pkg::ALU_LB, id_ctrl_pkg::ALU_LBU,
		id_ctrl_pkg::ALU_LH, id_ctrl_pkg::ALU_LHU, id_ctrl_pkg::ALU_LW};
	assign rs1_hazard = ctrl_i.rs1_read && (ctrl_i.rs1 == ex_rd_i);
	assign rs2_hazard = ctrl_i.rs2_read && (ctrl_i.rs2 == ex_rd_i);
	assign stall_o = ex_is_load && (rs1_hazard || rs2_hazard);

endmodule

`default_nettype wire

// File: rtl/id_branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_cfg.svh"

module id_branch_unit (
	input id_ctrl_pkg::id_ctrl_t ctrl_i,
	input id_ctrl_pkg::word_t imm_i,
	input id_ctrl_pkg::word_t pc_i,
	input id_ctrl_pkg::word_t op1_i,
	input id_ctrl_pkg::word_t op2_i,
	output id_ctrl_pkg::branch_t branch_o
);

	logic op_eq;
	logic op_lt;   // signed
	logic op_ltu;
	logic cond;
	id_ctrl_pkg::word_t jalr_sum;

	assign op_eq = (op1_i == op2_i);
	assign op_lt = ($signed(op1_i) < $signed(op2_i));
	assign op_ltu = (op1_i < op2_i);
	assign jalr_sum = op1_i + imm_i;

	always_comb begin
		case (ctrl_i.alu_op)
			id_ctrl_pkg::ALU_BEQ: cond = op_eq;
			id_ctrl_pkg::ALU_BNE: cond = !op_eq;
			id_ctrl_pkg::ALU_BLT: cond = op_lt;
			id_ctrl_pkg::ALU_BGE: cond = !op_lt;
			id_ctrl_pkg::ALU_BLTU: cond = op_ltu;
			id_ctrl_pkg::ALU_BGEU: cond = !op_ltu;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		branch_o.taken = 1'b0;
		branch_o.target = '0;
		branch_o.link = '0;
		if (ctrl_i.is_jalr) begin
			branch_o.taken = 1'b1;
			branch_o.target = {jalr_sum[`ID_XLEN-1:1], 1'b0};  // lsb cleared per spec
			branch_o.link = pc_i + id_ctrl_pkg::word_t'(`ID_LINK_OFFSET);
		end else if (ctrl_i.is_jal) begin
			branch_o.taken = 1'b1;
			branch_o.target = pc_i + imm_i;
			branch_o.link = pc_i + id_ctrl_pkg::word_t'(`ID_LINK_OFFSET);
		end else if (ctrl_i.is_branch && cond) begin
			branch_o.taken = 1'b1;
			branch_o.target = pc_i + imm_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
	input logic clk,
	input logic arst_n_i,
	input logic stall_i,
	input id_ctrl_pkg::id_ex_t d_i,
	output id_ctrl_pkg::id_ex_t q_o
);

	id_ctrl_pkg::id_ex_t bubble;

	// no-op slot, nothing written back
	always_comb begin
		bubble.alu_op = id_ctrl_pkg::ALU_NOP;
		bubble.alu_sel = id_ctrl_pkg::SEL_NOP;
		bubble.op1 = '0;
		bubble.op2 = '0;
		bubble.rd = '0;
		bubble.rd_write = 1'b0;
		bubble.link = '0;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			q_o <= bubble;
		end else if (stall_i) begin
			// ID instruction is held upstream, EX gets a bubble
			q_o <= bubble;
		end else begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
	input logic clk,
	input logic arst_n_i,
	input id_ctrl_pkg::word_t pc_i,
	input id_ctrl_pkg::inst_t inst_i,
	input id_ctrl_pkg::word_t rs1_data_i,
	input id_ctrl_pkg::word_t rs2_data_i,
	input id_ctrl_pkg::fwd_t ex_fwd_i,
	input id_ctrl_pkg::fwd_t mem_fwd_i,
	output id_ctrl_pkg::reg_addr_t rs1_addr_o,
	output logic rs1_read_o,
	output id_ctrl_pkg::reg_addr_t rs2_addr_o,
	output logic rs2_read_o,
	output id_ctrl_pkg::branch_t branch_o,
	output logic stall_o,
	output id_ctrl_pkg::id_ex_t id_ex_o
);

	id_ctrl_pkg::id_ctrl_t ctrl;
	id_ctrl_pkg::word_t imm;
	id_ctrl_pkg::word_t op1;
	id_ctrl_pkg::word_t op2;
	id_ctrl_pkg::id_ex_t id_ex_d;

	// register file read ports
	assign rs1_addr_o = ctrl.rs1;
	assign rs1_read_o = ctrl.rs1_read;
	assign rs2_addr_o = ctrl.rs2;
	assign rs2_read_o = ctrl.rs2_read;

	assign id_ex_d = '{
		alu_op: ctrl.alu_op,
		alu_sel: ctrl.alu_sel,
		op1: op1,
		op2: op2,
		rd: ctrl.rd,
		rd_write: ctrl.rd_write,
		link: branch_o.link
	};

	id_decoder decoder_inst (
		.inst_i(inst_i),
		.ctrl_o(ctrl),
		.imm_o(imm)
	);

	id_operand_mux operand_mux_inst (
		.ctrl_i(ctrl),
		.imm_i(imm),
		.pc_i(pc_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.ex_fwd_i(ex_fwd_i),
		.mem_fwd_i(mem_fwd_i),
		.ex_alu_op_i(id_ex_o.alu_op),  // instruction now in EX
		.ex_rd_i(id_ex_o.rd),
		.op1_o(op1),
		.op2_o(op2),
		.stall_o(stall_o)
	);

	id_branch_unit branch_unit_inst (
		.ctrl_i(ctrl),
		.imm_i(imm),
		.pc_i(pc_i),
		.op1_i(op1),
		.op2_i(op2),
		.branch_o(branch_o)
	);

	id_ex_reg id_ex_reg_inst (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.stall_i(stall_o),
		.d_i(id_ex_d),
		.q_o(id_ex_o)
	);

endmodule

`default_nettype wire

// File: verification/id_checker.sv
`timescale 1ns/10ps
`default_nettype none

module id_checker (
	input logic clk_i,
	input logic active_i,
	input id_ctrl_pkg::reg_addr_t rs1_addr_i,
	input logic rs1_read_i,
	input id_ctrl_pkg::reg_addr_t rs2_addr_i,
	input logic rs2_read_i,
	input id_ctrl_pkg::branch_t branch_i,
	input logic stall_i,
	input id_ctrl_pkg::id_ex_t id_ex_i,
	input id_ctrl_pkg::reg_addr_t exp_rs1_addr_i,
	input logic exp_rs1_read_i,
	input id_ctrl_pkg::reg_addr_t exp_rs2_addr_i,
	input logic exp_rs2_read_i,
	input id_ctrl_pkg::branch_t exp_branch_i,
	input logic exp_stall_i,
	input id_ctrl_pkg::id_ex_t exp_id_ex_i,
	output int err_count_o,
	output int check_count_o
);

	int err_count = 0;
	int check_count = 0;

	assign err_count_o = err_count;
	assign check_count_o = check_count;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// midway between edges, inputs were driven 2 ns after the last rising edge
	always @(negedge clk_i) begin
		if (active_i) begin
			compare("rs1_read_o", 32'(exp_rs1_read_i), 32'(rs1_read_i));
			compare("rs2_read_o", 32'(exp_rs2_read_i), 32'(rs2_read_i));
			if (exp_rs1_read_i) begin
				compare("rs1_addr_o", 32'(exp_rs1_addr_i), 32'(rs1_addr_i));
			end
			if (exp_rs2_read_i) begin
				compare("rs2_addr_o", 32'(exp_rs2_addr_i), 32'(rs2_addr_i));
			end
			compare("stall_o", 32'(exp_stall_i), 32'(stall_i));
			compare("branch_o.taken", 32'(exp_branch_i.taken), 32'(branch_i.taken));
			compare("branch_o.target", exp_branch_i.target, branch_i.target);
			compare("branch_o.link", exp_branch_i.link, branch_i.link);
			// id_ex_o holds what was captured at the last edge
			compare("id_ex_o.alu_op", 32'(exp_id_ex_i.alu_op), 32'(id_ex_i.alu_op));
			compare("id_ex_o.alu_sel", 32'(exp_id_ex_i.alu_sel), 32'(id_ex_i.alu_sel));
			compare("id_ex_o.op1", exp_id_ex_i.op1, id_ex_i.op1);
			compare("id_ex_o.op2", exp_id_ex_i.op2, id_ex_i.op2);
			compare("id_ex_o.rd", 32'(exp_id_ex_i.rd), 32'(id_ex_i.rd));
			compare("id_ex_o.rd_write", 32'(exp_id_ex_i.rd_write), 32'(id_ex_i.rd_write));
			compare("id_ex_o.link", exp_id_ex_i.link, id_ex_i.link);
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "id_cfg.svh"

module tb_id_stage;

	localparam int NUM_TESTS = 5;
	localparam int VEC_PER_TEST = 40;
	localparam int CLK_PERIOD = 20;
	localparam logic [2:0] LOAD_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	localparam logic [2:0] STORE_F3 [3] = '{3'd0, 3'd1, 3'd2};
	localparam logic [2:0] BRANCH_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	logic clk;
	logic arst_n;
	logic active;
	id_ctrl_pkg::word_t pc;
	id_ctrl_pkg::inst_t inst;
	id_ctrl_pkg::word_t rs1_data;
	id_ctrl_pkg::word_t rs2_data;
	id_ctrl_pkg::fwd_t ex_fwd;
	id_ctrl_pkg::fwd_t mem_fwd;
	id_ctrl_pkg::reg_addr_t rs1_addr;
	id_ctrl_pkg::reg_addr_t rs2_addr;
	logic rs1_read;
	logic rs2_read;
	logic stall;
	id_ctrl_pkg::branch_t branch;
	id_ctrl_pkg::id_ex_t id_ex;

	// model state and expectations
	id_ctrl_pkg::reg_addr_t exp_rs1_addr;
	id_ctrl_pkg::reg_addr_t exp_rs2_addr;
	logic exp_rs1_read;
	logic exp_rs2_read;
	logic exp_stall;
	id_ctrl_pkg::branch_t exp_branch;
	id_ctrl_pkg::id_ex_t exp_id_ex;
	id_ctrl_pkg::id_ex_t ex_next;  // what the next edge captures
	id_ctrl_pkg::word_t rf [32];
	logic [31:0] lcg_state;
	logic [31:0] reg_mask;
	int err_count;
	int check_count;

	always #(CLK_PERIOD/2) clk = ~clk;

	// register file read is combinational, x0 reads zero
	assign rs1_data = rf[rs1_addr];
	assign rs2_data = rf[rs2_addr];

	id_stage id_stage_inst (
		.clk(clk),
		.arst_n_i(arst_n),
		.pc_i(pc),
		.inst_i(inst),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.ex_fwd_i(ex_fwd),
		.mem_fwd_i(mem_fwd),
		.rs1_addr_o(rs1_addr),
		.rs1_read_o(rs1_read),
		.rs2_addr_o(rs2_addr),
		.rs2_read_o(rs2_read),
		.branch_o(branch),
		.stall_o(stall),
		.id_ex_o(id_ex)
	);

	id_checker checker_inst (
		.clk_i(clk),
		.active_i(active),
		.rs1_addr_i(rs1_addr),
		.rs1_read_i(rs1_read),
		.rs2_addr_i(rs2_addr),
		.rs2_read_i(rs2_read),
		.branch_i(branch),
		.stall_i(stall),
		.id_ex_i(id_ex),
		.exp_rs1_addr_i(exp_rs1_addr),
		.exp_rs1_read_i(exp_rs1_read),
		.exp_rs2_addr_i(exp_rs2_addr),
		.exp_rs2_read_i(exp_rs2_read),
		.exp_branch_i(exp_branch),
		.exp_stall_i(exp_stall),
		.exp_id_ex_i(exp_id_ex),
		.err_count_o(err_count),
		.check_count_o(check_count)
	);

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int n);
		return int'((rand_word() >> 8) % n);  // low LCG bits are weak
	endfunction

	function automatic id_ctrl_pkg::fwd_t rand_fwd();
		id_ctrl_pkg::fwd_t f;
		f.we = 1'(rand_word() >> 31);
		f.rd = id_ctrl_pkg::reg_addr_t'(rand_word() & 32'd3);  // small range, x0 included
		f.data = rand_word();
		return f;
	endfunction

	// 0 I-ALU, 1 R-ALU, 2 load, 3 store, 4 LUI, 5 AUIPC, 6 branch, 7 JAL, 8 JALR
	function automatic id_ctrl_pkg::inst_t make_inst(input int cls);
		logic [31:0] w;
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		w = rand_word();
		f3 = w[14:12];
		f7 = w[31:25];
		rs1 = 5'(rand_word() & reg_mask);
		rs2 = 5'(rand_word() & reg_mask);
		rd = 5'(rand_word() & reg_mask);
		opc = 7'b0010011;
		case (cls)
			0: begin
				if (f3 == 3'd1) f7 = 7'h00;
				else if (f3 == 3'd5) f7 = w[30] ? 7'h20 : 7'h00;
			end
			1: begin
				opc = 7'b0110011;
				f7 = (w[1:0] == 2'd0) ? 7'h01 : 7'h00;
				if (w[1:0] == 2'd3) begin  // SUB or SRA
					f7 = 7'h20;
					f3 = w[20] ? 3'd5 : 3'd0;
				end
			end
			2: begin
				opc = 7'b0000011;
				f3 = LOAD_F3[rand_range(5)];
			end
			3: begin
				opc = 7'b0100011;
				f3 = STORE_F3[rand_range(3)];
			end
			4: opc = 7'b0110111;
			5: opc = 7'b0010111;
			6: begin
				opc = 7'b1100011;
				f3 = BRANCH_F3[rand_range(6)];
			end
			7: opc = 7'b1101111;
			default: begin
				opc = 7'b1100111;
				f3 = 3'd0;
			end
		endcase
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic id_ctrl_pkg::alu_sel_e result_class(input id_ctrl_pkg::alu_op_e op);
		case (op)
			id_ctrl_pkg::ALU_NOP: return id_ctrl_pkg::SEL_NOP;
			id_ctrl_pkg::ALU_AND, id_ctrl_pkg::ALU_OR, id_ctrl_pkg::ALU_XOR:
				return id_ctrl_pkg::SEL_LOGIC;
			id_ctrl_pkg::ALU_SLL, id_ctrl_pkg::ALU_SRL, id_ctrl_pkg::ALU_SRA:
				return id_ctrl_pkg::SEL_SHIFT;
			id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::ALU_SUB,
			id_ctrl_pkg::ALU_SLT, id_ctrl_pkg::ALU_SLTU:
				return id_ctrl_pkg::SEL_ARITH;
			id_ctrl_pkg::ALU_MUL, id_ctrl_pkg::ALU_MULH, id_ctrl_pkg::ALU_MULHSU,
			id_ctrl_pkg::ALU_MULHU: return id_ctrl_pkg::SEL_MUL;
			id_ctrl_pkg::ALU_DIV, id_ctrl_pkg::ALU_DIVU, id_ctrl_pkg::ALU_REM,
			id_ctrl_pkg::ALU_REMU: return id_ctrl_pkg::SEL_DIV;
			id_ctrl_pkg::ALU_LB, id_ctrl_pkg::ALU_LBU, id_ctrl_pkg::ALU_LH, id_ctrl_pkg::ALU_LHU,
			id_ctrl_pkg::ALU_LW, id_ctrl_pkg::ALU_SB, id_ctrl_pkg::ALU_SH, id_ctrl_pkg::ALU_SW:
				return id_ctrl_pkg::SEL_LOAD_STORE;
			default: return id_ctrl_pkg::SEL_JUMP_BRANCH;
		endcase
	endfunction

	// EX beats MEM beats the register file, x0 stays with the register file
	function automatic id_ctrl_pkg::word_t forward_value(input logic [4:0] a);
		if (a != 0 && ex_fwd.we && ex_fwd.rd == a) return ex_fwd.data;
		if (a != 0 && mem_fwd.we && mem_fwd.rd == a) return mem_fwd.data;
		return rf[a];
	endfunction

	task automatic predict();
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] imm;
		logic [31:0] o1;
		logic [31:0] o2;
		logic [31:0] link;
		logic [4:0] a1;
		logic [4:0] rd;
		logic r1;
		logic r2;
		logic wr;
		logic use_pc;
		logic cond;
		logic ex_load;
		id_ctrl_pkg::alu_op_e op;
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_u = {inst[31:12], 12'h000};
		imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		op = id_ctrl_pkg::ALU_NOP;
		{r1, r2, wr, use_pc} = 4'b0000;
		a1 = inst[19:15];
		rd = inst[11:7];
		imm = '0;
		case (inst[6:0])
			7'b0010011: begin
				{r1, wr} = 2'b11;
				imm = (inst[13:12] == 2'b01) ? {27'b0, inst[24:20]} : imm_i;  // shamt
				case (inst[14:12])
					3'd0: op = id_ctrl_pkg::ALU_ADD;
					3'd1: op = id_ctrl_pkg::ALU_SLL;
					3'd2: op = id_ctrl_pkg::ALU_SLT;
					3'd3: op = id_ctrl_pkg::ALU_SLTU;
					3'd4: op = id_ctrl_pkg::ALU_XOR;
					3'd5: op = inst[30] ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
					3'd6: op = id_ctrl_pkg::ALU_OR;
					default: op = id_ctrl_pkg::ALU_AND;
				endcase
			end
			7'b0110011: begin
				{r1, r2, wr} = 3'b111;
				if (inst[25]) begin
					op = id_ctrl_pkg::alu_op_e'(id_ctrl_pkg::ALU_MUL + inst[14:12]);
				end else begin
					case (inst[14:12])
						3'd0: op = inst[30] ? id_ctrl_pkg::ALU_SUB : id_ctrl_pkg::ALU_ADD;
						3'd1: op = id_ctrl_pkg::ALU_SLL;
						3'd2: op = id_ctrl_pkg::ALU_SLT;
						3'd3: op = id_ctrl_pkg::ALU_SLTU;
						3'd4: op = id_ctrl_pkg::ALU_XOR;
						3'd5: op = inst[30] ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
						3'd6: op = id_ctrl_pkg::ALU_OR;
						default: op = id_ctrl_pkg::ALU_AND;
					endcase
				end
			end
			7'b0000011: begin
				{r1, wr} = 2'b11;
				imm = imm_i;
				case (inst[14:12])
					3'd0: op = id_ctrl_pkg::ALU_LB;
					3'd1: op = id_ctrl_pkg::ALU_LH;
					3'd2: op = id_ctrl_pkg::ALU_LW;
					3'd4: op = id_ctrl_pkg::ALU_LBU;
					default: op = id_ctrl_pkg::ALU_LHU;
				endcase
			end
			7'b0100011: begin
				{r1, r2} = 2'b11;
				op = id_ctrl_pkg::alu_op_e'(id_ctrl_pkg::ALU_SB + inst[13:12]);
			end
			7'b0110111: begin  // LUI is x0 | imm
				{r1, wr} = 2'b11;
				a1 = '0;
				imm = imm_u;
				op = id_ctrl_pkg::ALU_OR;
			end
			7'b0010111: begin
				{wr, use_pc} = 2'b11;
				imm = imm_u;
				op = id_ctrl_pkg::ALU_ADD;
			end
			7'b1100011: begin
				{r1, r2} = 2'b11;
				imm = imm_b;
				case (inst[14:12])
					3'd0: op = id_ctrl_pkg::ALU_BEQ;
					3'd1: op = id_ctrl_pkg::ALU_BNE;
					3'd4: op = id_ctrl_pkg::ALU_BLT;
					3'd5: op = id_ctrl_pkg::ALU_BGE;
					3'd6: op = id_ctrl_pkg::ALU_BLTU;
					default: op = id_ctrl_pkg::ALU_BGEU;
				endcase
			end
			7'b1101111: begin
				wr = 1'b1;
				rd = 5'd1;
				imm = imm_j;
				op = id_ctrl_pkg::ALU_JAL;
			end
			7'b1100111: begin
				{r1, wr} = 2'b11;
				rd = 5'd1;
				imm = imm_i;
				op = id_ctrl_pkg::ALU_JALR;
			end
			default: ;
		endcase
		o1 = r1 ? forward_value(a1) : (use_pc ? pc : imm);
		o2 = r2 ? forward_value(inst[24:20]) : imm;
		case (op)
			id_ctrl_pkg::ALU_BEQ: cond = (o1 == o2);
			id_ctrl_pkg::ALU_BNE: cond = (o1 != o2);
			id_ctrl_pkg::ALU_BLT: cond = ($signed(o1) < $signed(o2));
			id_ctrl_pkg::ALU_BGE: cond = ($signed(o1) >= $signed(o2));
			id_ctrl_pkg::ALU_BLTU: cond = (o1 < o2);
			id_ctrl_pkg::ALU_BGEU: cond = (o1 >= o2);
			default: cond = 1'b0;
		endcase
		link = '0;
		exp_branch = '0;
		if (op == id_ctrl_pkg::ALU_JAL || op == id_ctrl_pkg::ALU_JALR) begin
			link = pc + `ID_LINK_OFFSET;
			exp_branch.taken = 1'b1;
			exp_branch.link = link;
			exp_branch.target = (op == id_ctrl_pkg::ALU_JAL) ? pc + imm : (o1 + imm) & ~32'd1;
		end else if (cond) begin
			exp_branch.taken = 1'b1;
			exp_branch.target = pc + imm;
		end
		exp_rs1_addr = a1;
		exp_rs2_addr = inst[24:20];
		exp_rs1_read = r1;
		exp_rs2_read = r2;
		ex_load = exp_id_ex.alu_op inside {id_ctrl_pkg::ALU_LB, id_ctrl_pkg::ALU_LBU,
			id_ctrl_pkg::ALU_LH, id_ctrl_pkg::ALU_LHU, id_ctrl_pkg::ALU_LW};
		exp_stall = ex_load && ((r1 && a1 == exp_id_ex.rd) ||
			(r2 && inst[24:20] == exp_id_ex.rd));
		if (exp_stall) ex_next = '0;  // bubble
		else ex_next = '{op, result_class(op), o1, o2, rd, wr, link};
	endtask

	task automatic apply(input logic [31:0] w, input logic [31:0] p,
		input id_ctrl_pkg::fwd_t ef, input id_ctrl_pkg::fwd_t mf);
		@(posedge clk);
		#2;
		exp_id_ex = ex_next;
		inst = w;
		pc = p;
		ex_fwd = ef;
		mem_fwd = mf;
		predict();
	endtask

	task automatic finish_test(input int num, input string name, input int errs_before);
		@(negedge clk);
		#1;
		$display("test %0d %s: %0d errors", num, name, err_count - errs_before);
	endtask

	initial begin
		int base;
		int r;
		logic [31:0] w;
		clk = 1'b0;
		arst_n = 1'b0;
		active = 1'b0;
		lcg_state = 32'd72;
		reg_mask = 32'd31;
		inst = make_inst(1);  // a live instruction that the reset must keep out of id_ex_o
		pc = '0;
		ex_fwd = '0;
		mem_fwd = '0;
		exp_id_ex = '0;
		rf[0] = '0;
		for (int i = 1; i < 32; i++) rf[i] = rand_word();
		predict();
		#1;
		active = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;

		apply('0, '0, '0, '0);
		apply('0, '0, '0, '0);
		finish_test(1, "reset bubble", 0);

		base = err_count;
		for (int i = 0; i < VEC_PER_TEST; i++) begin
			apply(make_inst(rand_range(6)), rand_word() & ~32'd3, '0, '0);
		end
		finish_test(2, "decode", base);

		base = err_count;
		reg_mask = 32'd3;  // crowd sources onto x0..x3
		for (int i = 0; i < VEC_PER_TEST; i++) begin
			apply(make_inst(rand_range(4)), rand_word() & ~32'd3, rand_fwd(), rand_fwd());
		end
		finish_test(3, "forwarding", base);

		base = err_count;
		reg_mask = 32'd7;
		for (int i = 0; i < VEC_PER_TEST; i++) begin
			apply(make_inst(6 + rand_range(3)), rand_word() & ~32'd3, '0, '0);
		end
		finish_test(4, "branch and jump", base);

		base = err_count;
		for (int i = 0; i < VEC_PER_TEST / 5; i++) begin
			r = 1 + rand_range(7);
			w = make_inst(2);
			w[11:7] = 5'(r);
			apply(w, '0, '0, '0);
			w = make_inst(1);
			w[19:15] = 5'(r);
			apply(w, 32'h100, '0, '0);  // dependent, stalls
			apply(w, 32'h100, '0, '0);  // held instruction goes through
			w = make_inst(2);
			w[11:7] = 5'(r);
			apply(w, '0, '0, '0);
			w = make_inst(1);
			w[19:15] = 5'(r % 7 + 1);
			w[24:20] = 5'(r % 7 + 1);
			apply(w, 32'h200, '0, '0);
		end
		finish_test(5, "load-use", base);

		$display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, err_count);
		if (err_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// reset, end-of-test waits and slack fit into the extra 20 cycles
	initial begin
		#((NUM_TESTS * VEC_PER_TEST + 20) * CLK_PERIOD);
		$display("timeout: the tests did not finish in time, the run looks hung");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/rv_isa_pkg.sv
rtl/id_ctrl_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_branch_unit.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
verification/id_checker.sv
verification/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv_isa_pkg.sv
      - rtl/id_ctrl_pkg.sv
      - rtl/id_decoder.sv
      - rtl/id_operand_mux.sv
      - rtl/id_branch_unit.sv
      - rtl/id_ex_reg.sv
      - rtl/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/id_checker.sv
      - verification/tb_id_stage.sv
